// ==== include/mips_config.svh ====
`ifndef MIPS_CONFIG_SVH
`define MIPS_CONFIG_SVH

`define XLEN      32
`define REG_COUNT 32
`define PC_STEP   4
`define RA_REG    31 // link register written by jal
`define RESET_PC  0

`endif

// ==== hdl/mips_pkg.sv ====
`include "mips_config.svh"

package mips_pkg;

    typedef logic [`XLEN-1:0] word_t;
    typedef logic [$clog2(`REG_COUNT)-1:0] reg_idx_t;

    // primary opcode field, inst[31:26]
    typedef enum logic [5:0] {
        RTYPE = 6'b000000,
        BGEZ  = 6'b000001, // regimm group
        J     = 6'b000010,
        JAL   = 6'b000011,
        BEQ   = 6'b000100,
        BNE   = 6'b000101,
        BLEZ  = 6'b000110,
        BGTZ  = 6'b000111,
        ADDI  = 6'b001000,
        ADDIU = 6'b001001,
        SLTI  = 6'b001010,
        ANDI  = 6'b001100,
        ORI   = 6'b001101,
        XORI  = 6'b001110,
        LUI   = 6'b001111,
        LW    = 6'b100011,
        SW    = 6'b101011
    } opcode_t;

    typedef enum logic [4:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } alu_op_t;

endpackage

// ==== hdl/alu.sv ====
`include "mips_config.svh"

module alu (
    input  mips_pkg::word_t   operand_a,
    input  mips_pkg::word_t   operand_b,
    input  mips_pkg::alu_op_t alu_operation,
    output mips_pkg::word_t   result,
    output logic              zero,
    output logic              negative
);
    import mips_pkg::*;

    logic [4:0] shamt;

    assign shamt = operand_a[4:0]; // shifts move b by a

    always_comb begin
        case (alu_operation)
            ALU_ADD: result = operand_a + operand_b;
            ALU_SUB: result = operand_a - operand_b;
            ALU_AND: result = operand_a & operand_b;
            ALU_OR:  result = operand_a | operand_b;
            ALU_XOR: result = operand_a ^ operand_b;
            ALU_NOR: result = ~(operand_a | operand_b);
            ALU_SLT: result = word_t'($signed(operand_a) < $signed(operand_b));
            ALU_SLL: result = operand_b << shamt;
            ALU_SRL: result = operand_b >> shamt;
            ALU_SRA: result = word_t'($signed(operand_b) >>> shamt);
            ALU_LUI: result = {operand_b[15:0], {(`XLEN-16){1'b0}}};
            default: result = '0;
        endcase
    end

    assign zero     = (result == '0);
    assign negative = result[`XLEN-1];

endmodule

// ==== hdl/fetch_stage.sv ====
`include "mips_config.svh"

module fetch_stage (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            pc_we,
    input  logic            stall,
    input  logic            flush,
    input  mips_pkg::word_t inst,
    input  logic            take_branch,
    input  logic            jump_mem,
    input  logic            jump_register_mem,
    input  mips_pkg::word_t branch_target_mem,
    input  mips_pkg::word_t jump_target_mem,
    input  mips_pkg::word_t rs_data_mem,
    output mips_pkg::word_t inst_addr,
    output mips_pkg::word_t inst_id,
    output mips_pkg::word_t pc_inc_id
);
    import mips_pkg::*;

    word_t pc;
    word_t pc_inc;
    word_t pc_next;

    assign pc_inc    = pc + word_t'(`PC_STEP);
    assign inst_addr = pc;

    // jr first, then j, then a taken branch
    always_comb begin
        if (jump_register_mem) begin
            pc_next = rs_data_mem;
        end else if (jump_mem) begin
            pc_next = jump_target_mem;
        end else if (take_branch) begin
            pc_next = branch_target_mem;
        end else begin
            pc_next = pc_inc;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= word_t'(`RESET_PC);
        end else if (pc_we) begin
            pc <= pc_next;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            inst_id <= '0;
        end else if (flush) begin
            inst_id <= '0; // bubble
        end else if (!stall) begin
            inst_id <= inst;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            pc_inc_id <= pc_inc;
        end
    end

endmodule

// ==== hdl/decode_stage.sv ====
`include "mips_config.svh"

module decode_stage (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               stall,
    input  logic               flush,
    input  mips_pkg::word_t    inst_id,
    input  mips_pkg::word_t    pc_inc_id,
    input  mips_pkg::word_t    rs_data,
    input  mips_pkg::word_t    rt_data,
    input  logic               reg_dest, reg_write_enable, alu_src,
    input  mips_pkg::alu_op_t  alu_operation,
    input  logic               mem_or_reg, pc_or_mem, branch, jump, jump_register,
    input  logic               does_shift_amount_need, is_unsigned, should_branch,
    output mips_pkg::reg_idx_t rs_num,
    output mips_pkg::reg_idx_t rt_num,
    output logic               reg_write_enable_ex, alu_src_ex,
    output mips_pkg::alu_op_t  alu_operation_ex,
    output logic               mem_or_reg_ex, pc_or_mem_ex, branch_ex, jump_ex,
    output logic               jump_register_ex, does_shift_amount_need_ex, should_branch_ex,
    output mips_pkg::word_t    rs_data_ex,
    output mips_pkg::word_t    rt_data_ex,
    output mips_pkg::word_t    imm_ex,
    output mips_pkg::word_t    shamt_ex,
    output mips_pkg::word_t    branch_offset_ex,
    output mips_pkg::word_t    jump_target_ex,
    output mips_pkg::word_t    pc_inc_ex,
    output mips_pkg::reg_idx_t rd_num_ex,
    output mips_pkg::opcode_t  opcode_ex,
    output mips_pkg::word_t    inst_ex
);
    import mips_pkg::*;

    word_t    sign_imm;
    word_t    imm;
    reg_idx_t rd_sel;
    reg_idx_t rd_num;

    assign rs_num   = inst_id[25:21];
    assign rt_num   = inst_id[20:16];
    assign sign_imm = {{(`XLEN-16){inst_id[15]}}, inst_id[15:0]};
    assign imm      = is_unsigned ? {{(`XLEN-16){1'b0}}, inst_id[15:0]} : sign_imm;
    assign rd_sel   = reg_dest ? inst_id[15:11] : rt_num; // r-type writes rd
    assign rd_num   = pc_or_mem ? reg_idx_t'(`RA_REG) : rd_sel;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n || flush) begin
            reg_write_enable_ex       <= 1'b0;
            alu_src_ex                <= 1'b0;
            alu_operation_ex          <= ALU_ADD;
            mem_or_reg_ex             <= 1'b0;
            pc_or_mem_ex              <= 1'b0;
            branch_ex                 <= 1'b0;
            jump_ex                   <= 1'b0;
            jump_register_ex          <= 1'b0;
            does_shift_amount_need_ex <= 1'b0;
            should_branch_ex          <= 1'b0;
            inst_ex                   <= '0;
        end else if (!stall) begin
            reg_write_enable_ex       <= reg_write_enable;
            alu_src_ex                <= alu_src;
            alu_operation_ex          <= alu_operation;
            mem_or_reg_ex             <= mem_or_reg;
            pc_or_mem_ex              <= pc_or_mem;
            branch_ex                 <= branch;
            jump_ex                   <= jump;
            jump_register_ex          <= jump_register;
            does_shift_amount_need_ex <= does_shift_amount_need;
            should_branch_ex          <= should_branch;
            inst_ex                   <= inst_id;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            rs_data_ex       <= rs_data;
            rt_data_ex       <= rt_data;
            imm_ex           <= imm;
            shamt_ex         <= word_t'(inst_id[10:6]);
            branch_offset_ex <= sign_imm << 2;
            jump_target_ex   <= {pc_inc_id[`XLEN-1:`XLEN-4], inst_id[25:0], 2'b00};
            pc_inc_ex        <= pc_inc_id;
            rd_num_ex        <= rd_num;
            opcode_ex        <= opcode_t'(inst_id[31:26]);
        end
    end

endmodule

// ==== hdl/reg_file.sv ====
`include "mips_config.svh"

module reg_file (
    input  logic               clk,
    input  logic               rst_n,
    input  mips_pkg::reg_idx_t rs_num,
    input  mips_pkg::reg_idx_t rt_num,
    input  mips_pkg::reg_idx_t rd_num,
    input  mips_pkg::word_t    rd_data,
    input  logic               rd_we,
    output mips_pkg::word_t    rs_data,
    output mips_pkg::word_t    rt_data
);
    import mips_pkg::*;

    word_t regs [`REG_COUNT];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_we && rd_num != '0) begin
            regs[rd_num] <= rd_data;
        end
    end

    // $zero is hardwired, a same-cycle write shows up on the read side
    assign rs_data = (rs_num == '0) ? '0 :
                     (rd_we && rd_num == rs_num) ? rd_data : regs[rs_num];
    assign rt_data = (rt_num == '0) ? '0 :
                     (rd_we && rd_num == rt_num) ? rd_data : regs[rt_num];

endmodule

// ==== hdl/execute_stage.sv ====
module execute_stage (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               stall,
    input  logic               flush,
    input  logic               reg_write_enable_ex, alu_src_ex,
    input  mips_pkg::alu_op_t  alu_operation_ex,
    input  logic               mem_or_reg_ex, pc_or_mem_ex, branch_ex, jump_ex,
    input  logic               jump_register_ex, does_shift_amount_need_ex, should_branch_ex,
    input  mips_pkg::word_t    rs_data_ex,
    input  mips_pkg::word_t    rt_data_ex,
    input  mips_pkg::word_t    imm_ex,
    input  mips_pkg::word_t    shamt_ex,
    input  mips_pkg::word_t    branch_offset_ex,
    input  mips_pkg::word_t    jump_target_ex,
    input  mips_pkg::word_t    pc_inc_ex,
    input  mips_pkg::reg_idx_t rd_num_ex,
    input  mips_pkg::opcode_t  opcode_ex,
    input  mips_pkg::word_t    inst_ex,
    output logic               reg_write_enable_mem, mem_or_reg_mem, pc_or_mem_mem,
    output logic               branch_mem, jump_mem, jump_register_mem, should_branch_mem,
    output logic               zero_mem,
    output logic               negative_mem,
    output mips_pkg::word_t    alu_result_mem,
    output mips_pkg::word_t    rs_data_mem,
    output mips_pkg::word_t    rt_data_mem,
    output mips_pkg::word_t    branch_target_mem,
    output mips_pkg::word_t    jump_target_mem,
    output mips_pkg::word_t    pc_inc_mem,
    output mips_pkg::reg_idx_t rd_num_mem,
    output mips_pkg::opcode_t  opcode_mem,
    output mips_pkg::word_t    inst_mem
);
    import mips_pkg::*;

    word_t operand_a;
    word_t operand_b;
    word_t alu_result;
    logic  zero;
    logic  negative;

    assign operand_a = does_shift_amount_need_ex ? shamt_ex : rs_data_ex;
    assign operand_b = alu_src_ex ? imm_ex : rt_data_ex;

    alu alu_inst (
        .operand_a    (operand_a),
        .operand_b    (operand_b),
        .alu_operation(alu_operation_ex),
        .result       (alu_result),
        .zero         (zero),
        .negative     (negative)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n || flush) begin
            reg_write_enable_mem <= 1'b0;
            mem_or_reg_mem       <= 1'b0;
            pc_or_mem_mem        <= 1'b0;
            branch_mem           <= 1'b0;
            jump_mem             <= 1'b0;
            jump_register_mem    <= 1'b0;
            should_branch_mem    <= 1'b0;
            inst_mem             <= '0;
        end else if (!stall) begin
            reg_write_enable_mem <= reg_write_enable_ex;
            mem_or_reg_mem       <= mem_or_reg_ex;
            pc_or_mem_mem        <= pc_or_mem_ex;
            branch_mem           <= branch_ex;
            jump_mem             <= jump_ex;
            jump_register_mem    <= jump_register_ex;
            should_branch_mem    <= should_branch_ex;
            inst_mem             <= inst_ex;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            zero_mem          <= zero;
            negative_mem      <= negative;
            alu_result_mem    <= alu_result;
            rs_data_mem       <= rs_data_ex; // jr target
            rt_data_mem       <= rt_data_ex;
            branch_target_mem <= pc_inc_ex + branch_offset_ex;
            jump_target_mem   <= jump_target_ex;
            pc_inc_mem        <= pc_inc_ex;
            rd_num_mem        <= rd_num_ex;
            opcode_mem        <= opcode_ex;
        end
    end

endmodule

// ==== hdl/mem_wb_stage.sv ====
module mem_wb_stage (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               stall,
    input  logic               reg_write_enable_mem, mem_or_reg_mem, pc_or_mem_mem,
    input  logic               branch_mem, should_branch_mem,
    input  logic               zero_mem,
    input  logic               negative_mem,
    input  mips_pkg::word_t    alu_result_mem,
    input  mips_pkg::word_t    rt_data_mem,
    input  mips_pkg::word_t    pc_inc_mem,
    input  mips_pkg::reg_idx_t rd_num_mem,
    input  mips_pkg::opcode_t  opcode_mem,
    input  mips_pkg::word_t    mem_rdata,
    output mips_pkg::word_t    mem_addr,
    output mips_pkg::word_t    mem_wdata,
    output logic               take_branch,
    output mips_pkg::reg_idx_t rd_num_wb,
    output mips_pkg::word_t    rd_data_wb,
    output logic               rd_we_wb
);
    import mips_pkg::*;

    logic  mem_or_reg_wb;
    logic  pc_or_mem_wb;
    word_t mem_rdata_wb;
    word_t alu_result_wb;
    word_t pc_inc_wb;

    assign mem_addr  = alu_result_mem;
    assign mem_wdata = rt_data_mem;

    // flags come from rs - rt, or rs alone for the compares against zero
    always_comb begin
        take_branch = 1'b0;
        if (should_branch_mem) begin
            case (opcode_mem)
                BEQ:     take_branch = zero_mem;
                BNE:     take_branch = !zero_mem;
                BLEZ:    take_branch = zero_mem || negative_mem;
                BGTZ:    take_branch = !zero_mem && !negative_mem;
                BGEZ:    take_branch = !negative_mem;
                default: take_branch = branch_mem; // no compare for this opcode
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_we_wb      <= 1'b0;
            mem_or_reg_wb <= 1'b0;
            pc_or_mem_wb  <= 1'b0;
        end else if (!stall) begin
            rd_we_wb      <= reg_write_enable_mem;
            mem_or_reg_wb <= mem_or_reg_mem;
            pc_or_mem_wb  <= pc_or_mem_mem;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            mem_rdata_wb  <= mem_rdata;
            alu_result_wb <= alu_result_mem;
            pc_inc_wb     <= pc_inc_mem;
            rd_num_wb     <= rd_num_mem;
        end
    end

    // jal links pc_inc, otherwise load data or alu result
    assign rd_data_wb = pc_or_mem_wb  ? pc_inc_wb :
                        mem_or_reg_wb ? mem_rdata_wb : alu_result_wb;

endmodule

// ==== hdl/mips_datapath.sv ====
module mips_datapath (
    input  logic              clk,
    input  logic              rst_n,
    input  mips_pkg::word_t   inst,
    output mips_pkg::word_t   inst_addr,
    input  logic              reg_dest, reg_write_enable, alu_src,
    input  mips_pkg::alu_op_t alu_operation,
    input  logic              mem_or_reg, pc_or_mem, branch, jump, jump_register,
    input  logic              does_shift_amount_need, is_unsigned, should_branch,
    input  logic              pc_we,
    input  logic              stall,
    input  logic              flush,
    output mips_pkg::word_t   mem_addr,
    output mips_pkg::word_t   mem_wdata,
    input  mips_pkg::word_t   mem_rdata,
    output mips_pkg::word_t   inst_id,
    output mips_pkg::word_t   inst_ex,
    output mips_pkg::word_t   inst_mem
);
    import mips_pkg::*;

    // IF/ID
    word_t    pc_inc_id;
    reg_idx_t rs_num;
    reg_idx_t rt_num;
    word_t    rs_data;
    word_t    rt_data;

    // ID/EX
    logic     reg_write_enable_ex, alu_src_ex, mem_or_reg_ex, pc_or_mem_ex;
    logic     branch_ex, jump_ex, jump_register_ex, does_shift_amount_need_ex;
    logic     should_branch_ex;
    alu_op_t  alu_operation_ex;
    word_t    rs_data_ex, rt_data_ex, imm_ex, shamt_ex;
    word_t    branch_offset_ex, jump_target_ex, pc_inc_ex;
    reg_idx_t rd_num_ex;
    opcode_t  opcode_ex;

    // EX/MEM
    logic     reg_write_enable_mem, mem_or_reg_mem, pc_or_mem_mem;
    logic     branch_mem, jump_mem, jump_register_mem, should_branch_mem;
    logic     zero_mem, negative_mem;
    word_t    alu_result_mem, rs_data_mem, rt_data_mem;
    word_t    branch_target_mem, jump_target_mem, pc_inc_mem;
    reg_idx_t rd_num_mem;
    opcode_t  opcode_mem;

    // MEM/WB and next pc
    logic     take_branch;
    reg_idx_t rd_num_wb;
    word_t    rd_data_wb;
    logic     rd_we_wb;

    fetch_stage fetch_stage_inst (.*);

    decode_stage decode_stage_inst (.*);

    reg_file reg_file_inst (
        .clk    (clk),
        .rst_n  (rst_n),
        .rs_num (rs_num),
        .rt_num (rt_num),
        .rd_num (rd_num_wb),
        .rd_data(rd_data_wb),
        .rd_we  (rd_we_wb),
        .rs_data(rs_data),
        .rt_data(rt_data)
    );

    execute_stage execute_stage_inst (.*);

    mem_wb_stage mem_wb_stage_inst (.*);

endmodule

// ==== verif/datapath_tb.sv ====
module datapath_tb;
    import mips_pkg::*;

    localparam int CLK_PERIOD = 8;
    localparam int MAX_CYCLES = 20000;

    // control word layout {reg_dest, write, alu_src, alu_op[4:0], low flags}
    localparam logic [15:0] C_REG_DEST = 16'h8000;
    localparam logic [15:0] C_WRITE    = 16'h4000;
    localparam logic [15:0] C_ALU_SRC  = 16'h2000;
    localparam logic [15:0] C_MEM2REG  = 16'h0080;
    localparam logic [15:0] C_LINK     = 16'h0040;
    localparam logic [15:0] C_BRANCH   = 16'h0020;
    localparam logic [15:0] C_JUMP     = 16'h0010;
    localparam logic [15:0] C_JR       = 16'h0008;
    localparam logic [15:0] C_SHAMT    = 16'h0004;
    localparam logic [15:0] C_UNSIGNED = 16'h0002;
    localparam logic [15:0] C_SHOULD   = 16'h0001;

    // how a transfer target follows from the issue pc
    localparam int XFER_BRANCH = 0;
    localparam int XFER_JUMP   = 1;
    localparam int XFER_REG    = 2;

    logic    clk;
    logic    rst_n;
    word_t   inst;
    word_t   inst_addr;
    logic    reg_dest, reg_write_enable, alu_src;
    alu_op_t alu_operation;
    logic    mem_or_reg, pc_or_mem, branch, jump, jump_register;
    logic    does_shift_amount_need, is_unsigned, should_branch;
    logic    pc_we, stall, flush;
    word_t   mem_addr, mem_wdata, mem_rdata;
    word_t   inst_id, inst_ex, inst_mem;

    word_t       model_regs [32];
    logic [15:0] pending_ctrl;
    word_t       rdata_val;
    word_t       last_pc;
    int unsigned seed_dummy;

    mips_datapath mips_datapath_inst (
        .clk(clk), .rst_n(rst_n), .inst(inst), .inst_addr(inst_addr),
        .reg_dest(reg_dest), .reg_write_enable(reg_write_enable), .alu_src(alu_src),
        .alu_operation(alu_operation), .mem_or_reg(mem_or_reg), .pc_or_mem(pc_or_mem),
        .branch(branch), .jump(jump), .jump_register(jump_register),
        .does_shift_amount_need(does_shift_amount_need), .is_unsigned(is_unsigned),
        .should_branch(should_branch), .pc_we(pc_we), .stall(stall), .flush(flush),
        .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_rdata(mem_rdata),
        .inst_id(inst_id), .inst_ex(inst_ex), .inst_mem(inst_mem)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(CLK_PERIOD * MAX_CYCLES);
        $display("simulation ran past its cycle limit");
        $display("sim failed");
        $fatal(1, "watchdog expired");
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("sim failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check(input string test, input word_t expected, input word_t actual);
        if (expected !== actual) begin
            $display("ERR %s expected %h actual %h", test, expected, actual);
            $display("sim failed");
            $fatal(1, "stopping at first error");
        end
    endtask

    function automatic word_t sext16(input logic [15:0] v);
        return {{16{v[15]}}, v};
    endfunction

    function automatic word_t enc_i(input logic [5:0] op, input int rs, input int rt,
                                    input logic [15:0] imm);
        return {op, 5'(rs), 5'(rt), imm};
    endfunction

    function automatic word_t enc_r(input int rs, input int rt, input int rd, input int sh);
        return {6'b000000, 5'(rs), 5'(rt), 5'(rd), 5'(sh), 6'b100000};
    endfunction

    function automatic logic [15:0] ctrl_word(input alu_op_t op, input logic [15:0] flags);
        return flags | (16'(op) << 8);
    endfunction

    // reference alu where shifts move b by a[4:0]
    function automatic word_t alu_model(input alu_op_t op, input word_t a, input word_t b);
        case (op)
            ALU_ADD: return a + b;
            ALU_SUB: return a - b;
            ALU_AND: return a & b;
            ALU_OR:  return a | b;
            ALU_XOR: return a ^ b;
            ALU_NOR: return ~(a | b);
            ALU_SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ALU_SLL: return b << a[4:0];
            ALU_SRL: return b >> a[4:0];
            ALU_SRA: return $signed(b) >>> a[4:0];
            ALU_LUI: return {b[15:0], 16'h0000};
            default: return '0;
        endcase
    endfunction

    task automatic apply_ctrl(input logic [15:0] c);
        {reg_dest, reg_write_enable, alu_src} <= c[15:13];
        alu_operation <= alu_op_t'(c[12:8]);
        {mem_or_reg, pc_or_mem, branch, jump} <= c[7:4];
        {jump_register, does_shift_amount_need, is_unsigned, should_branch} <= c[3:0];
    endtask

    // one slot drives a new inst and the controls of the previous one
    task automatic step(input word_t word, input logic [15:0] c, input logic fl);
        @(posedge clk);
        inst      <= word;
        flush     <= fl;
        mem_rdata <= rdata_val;
        apply_ctrl(pending_ctrl);
        pending_ctrl = c;
        @(negedge clk);
        last_pc = inst_addr;
    endtask

    task automatic pad(input int n);
        repeat (n) step('0, '0, 1'b0);
    endtask

    task automatic wait_reset_pc();
        int n;
        n = 0;
        while (inst_addr !== word_t'(0)) begin
            @(negedge clk);
            n++;
            if (n > 16) report_failure("pc never settled at its reset value");
        end
    endtask

    task automatic do_imm(input logic [5:0] op, input alu_op_t aop, input logic uns,
                          input int rs, input int rt, input logic [15:0] imm);
        word_t       b;
        word_t       v;
        logic [15:0] flags;
        b = uns ? {16'h0000, imm} : sext16(imm);
        v = alu_model(aop, model_regs[rs], b);
        flags = C_WRITE | C_ALU_SRC | (uns ? C_UNSIGNED : 16'h0000);
        step(enc_i(op, rs, rt, imm), ctrl_word(aop, flags), 1'b0);
        if (rt != 0) model_regs[rt] = v;
        pad(2);
    endtask

    task automatic do_reg(input alu_op_t aop, input int rs, input int rt, input int rd);
        word_t v;
        v = alu_model(aop, model_regs[rs], model_regs[rt]);
        step(enc_r(rs, rt, rd, 0), ctrl_word(aop, C_REG_DEST | C_WRITE), 0);
        if (rd != 0) model_regs[rd] = v;
        pad(2);
    endtask

    task automatic do_shift(input alu_op_t aop, input int rt, input int rd, input int sh);
        word_t v;
        v = alu_model(aop, word_t'(sh), model_regs[rt]);
        step(enc_r(0, rt, rd, sh), ctrl_word(aop, C_REG_DEST | C_WRITE | C_SHAMT), 0);
        if (rd != 0) model_regs[rd] = v;
        pad(2);
    endtask

    task automatic store_check(input string test, input int rt, input word_t expected);
        logic [15:0] off;
        off = 16'($urandom);
        step(enc_i(SW, 0, rt, off), ctrl_word(ALU_ADD, C_ALU_SRC), 0);
        pad(3); // store now in MEM
        check({test, " addr"}, sext16(off), mem_addr);
        check({test, " data"}, expected, mem_wdata);
    endtask

    task automatic transfer(input string test, input word_t word, input logic [15:0] c,
                            input logic taken, input int kind, input word_t arg);
        word_t pc_of;
        word_t pc_inc;
        word_t target;
        step(word, c, 1'b0);
        pc_of  = last_pc;
        pc_inc = pc_of + 32'd4;
        case (kind)
            XFER_BRANCH: target = pc_inc + arg;
            XFER_JUMP:   target = {pc_inc[31:28], arg[27:0]};
            default:     target = arg;
        endcase
        if ((c & C_LINK) != '0) model_regs[31] = pc_inc; // return address of jal
        pad(2);
        step('0, '0, taken); // flush lands on the edge that loads the target
        step('0, '0, 1'b0);
        check(test, taken ? target : pc_of + 32'd16, inst_addr);
    endtask

    task automatic cond_branch(input string test, input logic [5:0] op,
                               input int rs, input int rt);
        word_t       diff;
        logic        taken;
        logic [15:0] off;
        diff = model_regs[rs] - model_regs[rt];
        off  = 16'($urandom_range(1, 64));
        case (op)
            BEQ:     taken = (diff == 0);
            BNE:     taken = (diff != 0);
            BLEZ:    taken = (diff == 0) || diff[31];
            BGTZ:    taken = (diff != 0) && !diff[31];
            default: taken = !diff[31];
        endcase
        transfer(test, enc_i(op, rs, rt, off),
                 ctrl_word(ALU_SUB, C_BRANCH | C_SHOULD), taken,
                 XFER_BRANCH, sext16(off) << 2);
    endtask

    task automatic test_fetch();
        word_t hist [$];
        word_t w;
        word_t exp_pc;
        wait_reset_pc();
        check("fetch reset", 32'd0, inst_addr);
        exp_pc = 0;
        @(posedge clk);
        pc_we <= 1'b1;
        @(negedge clk);
        check("fetch enable edge", exp_pc, inst_addr);
        repeat (3) begin
            @(posedge clk);
            @(negedge clk);
            exp_pc += 4;
            check("fetch advance", exp_pc, inst_addr);
        end
        @(posedge clk);
        pc_we <= 1'b0;
        @(negedge clk);
        exp_pc += 4;
        check("fetch last advance", exp_pc, inst_addr);
        repeat (2) begin
            @(posedge clk);
            @(negedge clk);
            check("fetch hold", exp_pc, inst_addr);
        end
        @(posedge clk);
        pc_we <= 1'b1;
        @(negedge clk);
        check("fetch resume", exp_pc, inst_addr);
        for (int i = 0; i < 6; i++) begin
            w = $urandom;
            hist.push_back(w);
            step(w, '0, 1'b0);
            if (i >= 1) check("pipe id", hist[i-1], inst_id);
            if (i >= 2) check("pipe ex", hist[i-2], inst_ex);
            if (i >= 3) check("pipe mem", hist[i-3], inst_mem);
        end
        pad(3);
    endtask

    task automatic test_alu();
        alu_op_t ops [7];
        ops = '{ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR, ALU_SLT};
        for (int r = 1; r <= 4; r++) do_imm(ADDIU, ALU_ADD, 1'b0, 0, r, 16'($urandom));
        do_imm(ORI, ALU_OR, 1'b1, 1, 8, 16'($urandom) | 16'h8000); // zero extended
        do_imm(ANDI, ALU_AND, 1'b1, 2, 9, 16'($urandom) | 16'h8000);
        for (int i = 0; i < 7; i++) do_reg(ops[i], i % 4 + 1, (i + 1) % 4 + 1, 10 + i);
        for (int r = 1; r <= 16; r++) begin
            if (r < 5 || r > 7) store_check("alu", r, model_regs[r]);
        end
    endtask

    task automatic test_shift();
        do_imm(ADDIU, ALU_ADD, 1'b0, 0, 4, 16'($urandom) | 16'h8000); // negative for sra
        do_shift(ALU_SLL, 1, 17, $urandom_range(0, 31));
        do_shift(ALU_SRL, 4, 18, $urandom_range(0, 31));
        do_shift(ALU_SRA, 4, 19, $urandom_range(1, 31));
        do_imm(LUI, ALU_LUI, 1'b0, 0, 20, 16'($urandom));
        for (int r = 17; r <= 20; r++) store_check("shift lui", r, model_regs[r]);
        do_imm(ADDIU, ALU_ADD, 1'b0, 1, 0, 16'h0005);
        store_check("zero reg", 0, 32'd0);
    endtask

    task automatic test_load();
        rdata_val = $urandom;
        step(enc_i(LW, 0, 22, 16'h0040), ctrl_word(ALU_ADD, C_WRITE | C_ALU_SRC | C_MEM2REG), 0);
        model_regs[22] = rdata_val;
        pad(3);
        rdata_val = ~rdata_val; // only the MEM cycle of the load counts
        pad(1);
        store_check("load", 22, model_regs[22]);
    endtask

    task automatic test_transfer();
        do_imm(ADDIU, ALU_ADD, 1'b0, 0, 1, 16'($urandom));
        do_imm(ADDIU, ALU_ADD, 1'b0, 1, 2, 16'h0000);
        do_imm(ADDIU, ALU_ADD, 1'b0, 1, 3, 16'h0001);
        do_imm(ADDIU, ALU_ADD, 1'b0, 0, 4, 16'($urandom) | 16'h8000);
        do_imm(ADDIU, ALU_ADD, 1'b0, 0, 5, 16'($urandom_range(1, 16'h7fff)));
        do_imm(ADDIU, ALU_ADD, 1'b0, 0, 6, 16'h0300);
        cond_branch("beq taken", BEQ, 1, 2);
        cond_branch("beq not taken", BEQ, 1, 3);
        cond_branch("bne taken", BNE, 1, 3);
        cond_branch("bne not taken", BNE, 1, 2);
        cond_branch("blez neg", BLEZ, 4, 0);
        cond_branch("blez pos", BLEZ, 5, 0);
        cond_branch("blez zero", BLEZ, 0, 0);
        cond_branch("bgtz pos", BGTZ, 5, 0);
        cond_branch("bgtz neg", BGTZ, 4, 0);
        cond_branch("bgez zero", BGEZ, 0, 0);
        cond_branch("bgez neg", BGEZ, 4, 0);
        transfer("j", {J, 26'h40}, ctrl_word(ALU_ADD, C_JUMP), 1'b1,
                 XFER_JUMP, {4'h0, 26'h40, 2'b00});
        transfer("jr", enc_r(6, 0, 0, 0), ctrl_word(ALU_ADD, C_JR), 1'b1,
                 XFER_REG, model_regs[6]);
        transfer("jal", {JAL, 26'h80}, ctrl_word(ALU_ADD, C_JUMP | C_LINK | C_WRITE), 1'b1,
                 XFER_JUMP, {4'h0, 26'h80, 2'b00});
        pad(1);
        store_check("jal link", 31, model_regs[31]);
    endtask

    task automatic test_stall();
        logic [15:0] off;
        word_t       snap [4];
        int          n;
        do_imm(ADDIU, ALU_ADD, 1'b0, 0, 21, 16'($urandom));
        off = 16'($urandom);
        step(enc_i(SW, 0, 21, off), ctrl_word(ALU_ADD, C_ALU_SRC), 0);
        step($urandom, '0, 1'b0); // filler word with no controls
        @(posedge clk);
        inst  <= $urandom; // kept out of IF/ID while stalled
        flush <= 1'b0;
        stall <= 1'b1;
        apply_ctrl(pending_ctrl);
        pending_ctrl = '0;
        @(negedge clk);
        snap = '{inst_id, inst_ex, inst_mem, mem_addr};
        n = $urandom_range(2, 6);
        repeat (n + 1) begin
            if (n == 0) begin
                @(posedge clk);
                stall <= 1'b0;
            end else begin
                @(posedge clk);
            end
            n--;
            @(negedge clk);
            check("stall id", snap[0], inst_id);
            check("stall ex", snap[1], inst_ex);
            check("stall mem", snap[2], inst_mem);
            check("stall addr", snap[3], mem_addr);
        end
        pad(1);
        check("stall resume addr", sext16(off), mem_addr);
        check("stall resume data", model_regs[21], mem_wdata);
        pad(2);
        store_check("after stall", 21, model_regs[21]);
    endtask

    initial begin
        seed_dummy = $urandom(32'h747e8eec);
        rst_n = 1'b0;
        inst = '0;
        {reg_dest, reg_write_enable, alu_src} = '0;
        alu_operation = ALU_ADD;
        {mem_or_reg, pc_or_mem, branch, jump, jump_register} = '0;
        {does_shift_amount_need, is_unsigned, should_branch} = '0;
        pc_we = 1'b0;
        stall = 1'b0;
        flush = 1'b0;
        mem_rdata = '0;
        rdata_val = '0;
        pending_ctrl = '0;
        last_pc = '0;
        for (int i = 0; i < 32; i++) model_regs[i] = '0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        test_fetch();
        test_alu();
        test_shift();
        test_load();
        test_transfer();
        test_stall();
        $display("sim passed");
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+include
hdl/mips_pkg.sv
hdl/alu.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/reg_file.sv
hdl/execute_stage.sv
hdl/mem_wb_stage.sv
hdl/mips_datapath.sv
verif/datapath_tb.sv
